/* psx_loader_pkg.sv */
/* PSX loader shared definitions
   Widths, region bases, file indices and the types passed between the loader blocks */
`default_nettype none

package psx_loader_pkg;

	// ==============================
	// Widths
	// ==============================
	localparam int HALF_W       = 16;
	localparam int WORD_W       = 32;
	localparam int IOCTL_ADDR_W = 27;
	localparam int TRACK_ADDR_W = 9;
	localparam int DISC_SIZE_W  = 30;
	localparam int IMAGE_SIZE_W = 64;
	localparam int INDEX_W      = 8;
	// CD images may use any of the upper index bits
	localparam int CD_MATCH_W   = 6;

	typedef logic [HALF_W-1:0]       half_t;
	typedef logic [WORD_W-1:0]       word_t;
	typedef logic [IOCTL_ADDR_W-1:0] ioctl_addr_t;
	typedef logic [TRACK_ADDR_W-1:0] track_addr_t;
	typedef logic [DISC_SIZE_W-1:0]  disc_size_t;
	typedef logic [IMAGE_SIZE_W-1:0] image_size_t;

	// Main RAM regions, byte addresses
	localparam ioctl_addr_t BIOS_BASE = 27'd2097152;
	localparam ioctl_addr_t EXE_BASE  = 27'd4194304;

	// ==============================
	// Host file indices
	// ==============================
	localparam logic [INDEX_W-1:0] IDX_BIOS      = 8'd0;
	localparam logic [INDEX_W-1:0] IDX_EXE       = 8'd1;
	localparam logic [INDEX_W-1:0] IDX_CD        = 8'd2;
	localparam logic [INDEX_W-1:0] IDX_SBI       = 8'd250;
	localparam logic [INDEX_W-1:0] IDX_TRACKINFO = 8'd251;
	localparam logic [INDEX_W-1:0] IDX_CODE      = 8'd255;

	typedef enum logic [2:0] {
		DL_NONE,
		DL_BIOS,
		DL_EXE,
		DL_CD,
		DL_SBI,
		DL_TRACKINFO,
		DL_CODE
	} dl_kind_t;

	typedef enum logic [1:0] {
		PK_IDLE,
		PK_WAIT_ACK,
		PK_WAIT_RELEASE
	} pack_state_t;

	// ==============================
	// Bundles
	// ==============================
	typedef struct packed {
		logic                download;
		logic [INDEX_W-1:0]  index;
		ioctl_addr_t         addr;
		half_t               data;
		logic                wr;
	} ioctl_bus_t;

	typedef struct packed {
		ioctl_addr_t addr;
		word_t       data;
	} ram_write_t;

	typedef struct packed {
		word_t flags;
		word_t address;
		word_t compare;
		word_t replace;
	} cheat_code_t;

	typedef struct packed {
		logic        mounted;
		image_size_t size;
	} image_mount_t;

endpackage

`default_nettype wire

/* download_decoder.sv */
/* Download decoder
   Registers the download kind from the host index and flags its start and end edges */
`timescale 1ns/1ps
`default_nettype none

module download_decoder import psx_loader_pkg::*; (
	input  logic       clk_1x,
	input  logic       reset,
	input  ioctl_bus_t ioctl,
	output dl_kind_t   kind,
	output logic       code_start,
	output logic       exe_end,
	output logic       cd_end,
	output logic       system_hold
);

	dl_kind_t kind_next;
	dl_kind_t kind_prev;

	// Index decode, exact match except for CD images
	always_comb begin
		kind_next = DL_NONE;
		if (ioctl.download) begin
			case (ioctl.index)
				IDX_BIOS:      kind_next = DL_BIOS;
				IDX_EXE:       kind_next = DL_EXE;
				IDX_SBI:       kind_next = DL_SBI;
				IDX_TRACKINFO: kind_next = DL_TRACKINFO;
				IDX_CODE:      kind_next = DL_CODE;
				default: begin
					if (ioctl.index[CD_MATCH_W-1:0] == IDX_CD[CD_MATCH_W-1:0]) begin
						kind_next = DL_CD;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			kind       <= DL_NONE;
			kind_prev  <= DL_NONE;
			code_start <= 1'b0;
			exe_end    <= 1'b0;
			cd_end     <= 1'b0;
		end else begin
			kind       <= kind_next;
			kind_prev  <= kind;
			// Edges of the registered kind
			code_start <= (kind == DL_CODE) && (kind_prev != DL_CODE);
			exe_end    <= (kind_prev == DL_EXE) && (kind != DL_EXE);
			cd_end     <= (kind_prev == DL_CD) && (kind != DL_CD);
		end
	end

	// Console stays in reset while its memory image is replaced
	assign system_hold = (kind == DL_BIOS) || (kind == DL_EXE) || (kind == DL_CD);

endmodule

`default_nettype wire

/* ram_word_packer.sv */
/* RAM word packer
   Joins host halfwords into words for main RAM over req/ack or for the track table */
`timescale 1ns/1ps
`default_nettype none

module ram_word_packer import psx_loader_pkg::*; (
	input  logic        clk_1x,
	input  logic        reset,
	input  ioctl_bus_t  ioctl,
	input  dl_kind_t    kind,
	output logic        ram_req,
	input  logic        ram_ack,
	output ram_write_t  ram_wr,
	output logic        ioctl_wait,
	output logic        trackinfo_write,
	output track_addr_t trackinfo_addr,
	output word_t       trackinfo_data
);

	pack_state_t state;
	half_t       lo_half;
	ioctl_addr_t addr_q;
	word_t       word_q;
	logic        ram_kind;
	logic        load_kind;
	logic        take_low;
	logic        take_high;

	// Region base for the address of the low halfword
	function automatic ioctl_addr_t region_base(input dl_kind_t k);
		case (k)
			DL_BIOS: return BIOS_BASE;
			DL_EXE:  return EXE_BASE;
			default: return '0;
		endcase
	endfunction

	assign ram_kind  = (kind == DL_BIOS) || (kind == DL_EXE);
	assign load_kind = ram_kind || (kind == DL_TRACKINFO);

	// Host only writes while not stalled, so new halves arrive in idle
	assign take_low  = load_kind && ioctl.wr && !ioctl.addr[1] && (state == PK_IDLE);
	assign take_high = load_kind && ioctl.wr && ioctl.addr[1] && (state == PK_IDLE);

	// ==============================
	// Word assembly
	// ==============================
	always_ff @(posedge clk_1x) begin
		if (take_low) begin
			lo_half <= ioctl.data;
			addr_q  <= ioctl.addr + region_base(kind);
		end
		if (take_high) begin
			word_q <= {ioctl.data, lo_half};
		end
	end

	// ==============================
	// Four-phase handshake
	// ==============================
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			state           <= PK_IDLE;
			ram_req         <= 1'b0;
			ioctl_wait      <= 1'b0;
			trackinfo_write <= 1'b0;
		end else begin
			trackinfo_write <= 1'b0;
			case (state)
				PK_IDLE: begin
					if (take_high) begin
						if (ram_kind) begin
							ram_req    <= 1'b1;
							ioctl_wait <= 1'b1;
							state      <= PK_WAIT_ACK;
						end else begin
							// Track table takes the word in one cycle
							trackinfo_write <= 1'b1;
						end
					end
				end
				PK_WAIT_ACK: begin
					if (ram_ack) begin
						ram_req <= 1'b0;
						state   <= PK_WAIT_RELEASE;
					end
				end
				PK_WAIT_RELEASE: begin
					// Host resumes once the responder has let go
					if (!ram_ack) begin
						ioctl_wait <= 1'b0;
						state      <= PK_IDLE;
					end
				end
				default: state <= PK_IDLE;
			endcase
		end
	end

	// Both write paths share the assembled word and address
	assign ram_wr         = '{addr: addr_q, data: word_q};
	assign trackinfo_addr = addr_q[TRACK_ADDR_W+1:2];
	assign trackinfo_data = word_q;

endmodule

`default_nettype wire

/* cheat_code_assembler.sv */
/* Cheat code assembler
   Collects eight halfwords of a code download into one 128-bit cheat code */
`timescale 1ns/1ps
`default_nettype none

module cheat_code_assembler import psx_loader_pkg::*; (
	input  logic        clk_1x,
	input  logic        reset,
	input  ioctl_bus_t  ioctl,
	input  dl_kind_t    kind,
	input  logic        code_start,
	output cheat_code_t cheat_code,
	output logic        cheat_valid,
	output logic        cheat_clear
);

	logic code_wr;

	assign code_wr = (kind == DL_CODE) && ioctl.wr;

	// Halfword placement by offset within the 16-byte code
	always_ff @(posedge clk_1x) begin
		if (code_wr) begin
			case (ioctl.addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= ioctl.data;
				4'd2:  cheat_code.flags[31:16]   <= ioctl.data;
				4'd4:  cheat_code.address[15:0]  <= ioctl.data;
				4'd6:  cheat_code.address[31:16] <= ioctl.data;
				4'd8:  cheat_code.compare[15:0]  <= ioctl.data;
				4'd10: cheat_code.compare[31:16] <= ioctl.data;
				4'd12: cheat_code.replace[15:0]  <= ioctl.data;
				4'd14: cheat_code.replace[31:16] <= ioctl.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Old cheat list is dropped when a new code file starts
			cheat_clear <= code_start;
			// Top replace half is the last of the group
			cheat_valid <= code_wr && (ioctl.addr[3:0] == 4'd14);
		end
	end

endmodule

`default_nettype wire

/* disc_tracker.sv */
/* Disc tracker
   Keeps disc presence and size from CD downloads or image mounts, and the libcrypt key */
`timescale 1ns/1ps
`default_nettype none

module disc_tracker import psx_loader_pkg::*; (
	input  logic         clk_1x,
	input  logic         reset,
	input  ioctl_bus_t   ioctl,
	input  dl_kind_t     kind,
	input  logic         cd_end,
	input  image_mount_t image,
	output logic         has_cd,
	output logic         new_cd,
	output disc_size_t   cd_size,
	output half_t        libcrypt_key
);

	logic mount_nonzero;

	assign mount_nonzero = image.mounted && (image.size != '0);

	// ==============================
	// Disc presence
	// ==============================
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			has_cd <= 1'b0;
			new_cd <= 1'b0;
		end else begin
			new_cd <= 1'b0;
			if (cd_end) begin
				has_cd <= 1'b1;
			end
			// A mount overrides a finished download in the same cycle
			if (image.mounted) begin
				has_cd <= mount_nonzero;
				new_cd <= mount_nonzero;
			end
		end
	end

	// ==============================
	// Size and key
	// ==============================
	always_ff @(posedge clk_1x) begin
		if (mount_nonzero) begin
			cd_size <= image.size[DISC_SIZE_W-1:0];
		end else if (cd_end) begin
			// Last download address equals the image length
			cd_size <= disc_size_t'(ioctl.addr);
		end
		if ((kind == DL_SBI) && ioctl.wr) begin
			libcrypt_key <= ioctl.data;
		end
	end

endmodule

`default_nettype wire

/* psx_loader_top.sv */
/* PSX loader top level
   Download decode, RAM and track-info loading, cheat codes and disc state */
`timescale 1ns/1ps
`default_nettype none

module psx_loader_top import psx_loader_pkg::*; (
	input  logic         clk_1x,
	input  logic         reset,
	input  ioctl_bus_t   ioctl,
	input  image_mount_t image,
	input  logic         ram_ack,
	output logic         ram_req,
	output logic         ioctl_wait,
	output ram_write_t   ram_wr,
	output logic         trackinfo_write,
	output track_addr_t  trackinfo_addr,
	output word_t        trackinfo_data,
	output cheat_code_t  cheat_code,
	output logic         cheat_valid,
	output logic         cheat_clear,
	output logic         load_exe,
	output logic         has_cd,
	output logic         new_cd,
	output disc_size_t   cd_size,
	output half_t        libcrypt_key,
	output logic         system_hold
);

	dl_kind_t kind;
	logic     code_start;
	logic     exe_end;
	logic     cd_end;

	download_decoder download_decoder_inst (
		.clk_1x, .reset, .ioctl, .kind, .code_start, .exe_end, .cd_end, .system_hold
	);

	ram_word_packer ram_word_packer_inst (
		.clk_1x, .reset, .ioctl, .kind,
		.ram_req, .ram_ack, .ram_wr, .ioctl_wait,
		.trackinfo_write, .trackinfo_addr, .trackinfo_data
	);

	cheat_code_assembler cheat_code_assembler_inst (
		.clk_1x, .reset, .ioctl, .kind, .code_start,
		.cheat_code, .cheat_valid, .cheat_clear
	);

	disc_tracker disc_tracker_inst (
		.clk_1x, .reset, .ioctl, .kind, .cd_end, .image,
		.has_cd, .new_cd, .cd_size, .libcrypt_key
	);

	// EXE start request, one cycle after the download ends
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			load_exe <= 1'b0;
		end else begin
			load_exe <= exe_end;
		end
	end

endmodule

`default_nettype wire

/* tb_psx_loader.sv */
/* PSX loader testbench
   Random downloads against a reference model, with the RAM side of the req/ack handshake */
`timescale 1ns/1ps
`default_nettype none

module tb_psx_loader import psx_loader_pkg::*; ();

	logic         clk_1x;
	logic         reset;
	ioctl_bus_t   ioctl;
	image_mount_t image;
	logic         ram_ack;
	logic         ram_req, ioctl_wait, trackinfo_write, cheat_valid, cheat_clear;
	logic         load_exe, has_cd, new_cd, system_hold;
	ram_write_t   ram_wr;
	track_addr_t  trackinfo_addr;
	word_t        trackinfo_data;
	cheat_code_t  cheat_code;
	disc_size_t   cd_size;
	half_t        libcrypt_key;

	integer     seed = 73056;
	ram_write_t exp_ram[$];
	int         ram_done = 0;
	int         n_clear = 0;
	int         n_valid = 0;
	int         n_track = 0;
	int         n_load_exe = 0;
	int         n_new_cd = 0;

	psx_loader_top psx_loader_top_inst (.*);

	initial begin : clock_gen
		clk_1x = 1'b0;
		forever #4 clk_1x = ~clk_1x;
	end

	// ==============================
	// Failure reporting and compares
	// ==============================
	task automatic stop_on_error();
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		stop_on_error();
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp_v);
		if (got !== exp_v) begin
			$display("error %s: got %h, expected %h", name, got, exp_v);
			stop_on_error();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp_v);
		if (got != exp_v) begin
			$display("error %s: got %h, expected %h", name, got, exp_v);
			stop_on_error();
		end
	endtask

	task automatic check_pack_state(input pack_state_t got, input pack_state_t exp_v);
		if (got !== exp_v) begin
			$display("error ram_word_packer state: got %s (%h), expected %s (%h)",
				got.name(), got, exp_v.name(), exp_v);
			stop_on_error();
		end
	endtask

	task automatic check_ram_write(input string name, input ram_write_t got, input ram_write_t exp_v);
		if (got !== exp_v) begin
			$display("error %s: got addr %h data %h, expected addr %h data %h",
				name, got.addr, got.data, exp_v.addr, exp_v.data);
			stop_on_error();
		end
	endtask

	task automatic check_track(input word_t got_d, input track_addr_t got_a,
		input word_t exp_d, input track_addr_t exp_a);
		if (got_d !== exp_d || got_a !== exp_a) begin
			$display("error trackinfo_data/trackinfo_addr: got %h/%h, expected %h/%h",
				got_d, got_a, exp_d, exp_a);
			stop_on_error();
		end
	endtask

	task automatic check_cheat(input cheat_code_t got, input cheat_code_t exp_v);
		if (got !== exp_v) begin
			$display("error cheat_code: got %h, expected %h", got, exp_v);
			stop_on_error();
		end
	endtask

	task automatic check_size(input disc_size_t got, input disc_size_t exp_v);
		if (got !== exp_v) begin
			$display("error cd_size: got %h, expected %h", got, exp_v);
			stop_on_error();
		end
	endtask

	task automatic check_half(input half_t got, input half_t exp_v);
		if (got !== exp_v) begin
			$display("error libcrypt_key: got %h, expected %h", got, exp_v);
			stop_on_error();
		end
	endtask

	// Pulse counts sampled before the edge updates them
	always @(posedge clk_1x) begin : pulse_counter
		if (!reset) begin
			if (cheat_clear) n_clear++;
			if (cheat_valid) n_valid++;
			if (trackinfo_write) n_track++;
			if (load_exe) n_load_exe++;
			if (new_cd) n_new_cd++;
		end
	end

	// ==============================
	// RAM responder
	// ==============================
	initial begin : ram_responder
		ram_write_t got;
		ram_write_t exp_w;
		int delay;
		int n;
		ram_ack = 1'b0;
		forever begin
			@(negedge clk_1x);
			if (ram_req && !ram_ack) begin
				got = ram_wr;
				if (exp_ram.size() == 0) begin
					$display("RAM request with no word expected from the host");
					stop_on_error();
				end
				exp_w = exp_ram.pop_front();
				check_ram_write("ram_wr", got, exp_w);
				check_bit("ioctl_wait", ioctl_wait, 1'b1);
				delay = $random(seed) & 7;
				repeat (delay) begin
					@(negedge clk_1x);
					check_bit("ram_req", ram_req, 1'b1);
					check_ram_write("ram_wr", ram_wr, got);
				end
				@(posedge clk_1x);
				ram_ack <= 1'b1;
				n = 0;
				@(negedge clk_1x);
				while (ram_req) begin
					n++;
					if (n > 20) report_timeout("ram_req to fall after ram_ack");
					@(negedge clk_1x);
				end
				check_ram_write("ram_wr", ram_wr, got);
				check_bit("ioctl_wait", ioctl_wait, 1'b1);
				@(posedge clk_1x);
				ram_ack <= 1'b0;
				ram_done++;
			end
		end
	end

	// ==============================
	// Host side
	// ==============================
	task automatic settle();
		repeat (5) @(negedge clk_1x);
	endtask

	task automatic start_download(input logic [INDEX_W-1:0] idx);
		@(posedge clk_1x);
		ioctl.download <= 1'b1;
		ioctl.index    <= idx;
		settle();
	endtask

	task automatic end_download();
		@(posedge clk_1x);
		ioctl.download <= 1'b0;
		settle();
	endtask

	// Host may only write while ioctl_wait is low
	task automatic host_write(input ioctl_addr_t a, input half_t d);
		int n;
		n = 0;
		@(negedge clk_1x);
		while (ioctl_wait) begin
			n++;
			if (n > 50) report_timeout("ioctl_wait to fall");
			@(negedge clk_1x);
		end
		@(posedge clk_1x);
		ioctl.wr   <= 1'b1;
		ioctl.addr <= a;
		ioctl.data <= d;
		@(posedge clk_1x);
		ioctl.wr <= 1'b0;
		@(negedge clk_1x);
	endtask

	task automatic load_ram_words(input logic [INDEX_W-1:0] idx, input ioctl_addr_t base,
		input int nwords);
		half_t       lo;
		half_t       hi;
		ioctl_addr_t a;
		ram_write_t  w;
		int          i;
		int          n;
		int          done0;
		int          exe0;
		done0 = ram_done;
		exe0  = n_load_exe;
		start_download(idx);
		for (i = 0; i < nwords; i++) begin
			a  = ioctl_addr_t'(4 * i);
			lo = half_t'($random(seed));
			hi = half_t'($random(seed));
			host_write(a, lo);
			check_bit("ram_req", ram_req, 1'b0);
			w.addr = base + a;
			w.data = {hi, lo};
			exp_ram.push_back(w);
			host_write(a + 27'd2, hi);
			check_bit("ram_req", ram_req, 1'b1);
			check_bit("ioctl_wait", ioctl_wait, 1'b1);
			check_bit("system_hold", system_hold, 1'b1);
		end
		n = 0;
		while (ioctl_wait || exp_ram.size() != 0) begin
			n++;
			if (n > 50) report_timeout("the last RAM handshake to finish");
			@(negedge clk_1x);
		end
		check_pack_state(psx_loader_top_inst.ram_word_packer_inst.state, PK_IDLE);
		check_count("RAM writes", ram_done - done0, nwords);
		end_download();
		check_bit("system_hold", system_hold, 1'b0);
		check_count("load_exe pulses", n_load_exe - exe0, (idx == IDX_EXE) ? 1 : 0);
	endtask

	task automatic load_track_info(input int nwords);
		half_t       lo;
		half_t       hi;
		ioctl_addr_t a;
		int          i;
		int          n0;
		n0 = n_track;
		start_download(IDX_TRACKINFO);
		check_bit("system_hold", system_hold, 1'b0);
		for (i = 0; i < nwords; i++) begin
			a  = ioctl_addr_t'($random(seed)) & 27'h7fffffc;
			lo = half_t'($random(seed));
			hi = half_t'($random(seed));
			host_write(a, lo);
			check_bit("trackinfo_write", trackinfo_write, 1'b0);
			host_write(a + 27'd2, hi);
			check_bit("trackinfo_write", trackinfo_write, 1'b1);
			check_track(trackinfo_data, trackinfo_addr, {hi, lo}, a[10:2]);
			check_bit("ram_req", ram_req, 1'b0);
		end
		end_download();
		check_count("trackinfo_write pulses", n_track - n0, nwords);
	endtask

	task automatic load_cheats(input int ncodes);
		half_t       h [8];
		cheat_code_t exp_c;
		int          j;
		int          k;
		int          clear0;
		int          valid0;
		clear0 = n_clear;
		valid0 = n_valid;
		start_download(IDX_CODE);
		check_count("cheat_clear pulses", n_clear - clear0, 1);
		for (j = 0; j < ncodes; j++) begin
			for (k = 0; k < 8; k++) begin
				h[k] = half_t'($random(seed));
				host_write(ioctl_addr_t'(16 * j + 2 * k), h[k]);
				check_bit("cheat_valid", cheat_valid, k == 7);
			end
			exp_c.flags   = {h[1], h[0]};
			exp_c.address = {h[3], h[2]};
			exp_c.compare = {h[5], h[4]};
			exp_c.replace = {h[7], h[6]};
			check_cheat(cheat_code, exp_c);
		end
		end_download();
		check_count("cheat_valid pulses", n_valid - valid0, ncodes);
		check_count("cheat_clear pulses", n_clear - clear0, 1);
	endtask

	task automatic mount_image(input image_size_t sz);
		@(posedge clk_1x);
		image.mounted <= 1'b1;
		image.size    <= sz;
		@(posedge clk_1x);
		image.mounted <= 1'b0;
		@(negedge clk_1x);
	endtask

	task automatic check_disc_state();
		logic [1:0]  upper;
		ioctl_addr_t base;
		ioctl_addr_t a;
		image_size_t sz;
		half_t       key;
		int          i;
		int          new0;
		new0  = n_new_cd;
		upper = 2'($random(seed));
		base  = ioctl_addr_t'($random(seed)) & 27'h3fffff0;
		a     = base;
		// CD files match on the low index bits only
		start_download({upper, IDX_CD[CD_MATCH_W-1:0]});
		check_bit("system_hold", system_hold, 1'b1);
		for (i = 0; i < 6; i++) begin
			a = base + ioctl_addr_t'(2 * i);
			host_write(a, half_t'($random(seed)));
		end
		check_bit("has_cd", has_cd, 1'b0);
		end_download();
		check_bit("has_cd", has_cd, 1'b1);
		check_size(cd_size, disc_size_t'(a));
		check_count("new_cd pulses", n_new_cd - new0, 0);
		mount_image('0);
		check_bit("new_cd", new_cd, 1'b0);
		check_bit("has_cd", has_cd, 1'b0);
		sz[63:32] = $random(seed);
		sz[31:0]  = $random(seed);
		if (sz == '0) sz = 64'd1;
		mount_image(sz);
		check_bit("new_cd", new_cd, 1'b1);
		check_bit("has_cd", has_cd, 1'b1);
		check_size(cd_size, sz[DISC_SIZE_W-1:0]);
		start_download(IDX_SBI);
		key = half_t'($random(seed));
		host_write(ioctl_addr_t'(0), key);
		check_half(libcrypt_key, key);
		end_download();
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin : stimulus
		ioctl = '0;
		image = '0;
		reset = 1'b1;
		repeat (2) @(posedge clk_1x);
		reset <= 1'b0;
		// Quiet outputs out of reset
		repeat (6) begin
			@(negedge clk_1x);
			check_bit("ram_req", ram_req, 1'b0);
			check_bit("ioctl_wait", ioctl_wait, 1'b0);
			check_bit("trackinfo_write", trackinfo_write, 1'b0);
			check_bit("cheat_valid", cheat_valid, 1'b0);
			check_bit("cheat_clear", cheat_clear, 1'b0);
			check_bit("load_exe", load_exe, 1'b0);
			check_bit("new_cd", new_cd, 1'b0);
			check_bit("has_cd", has_cd, 1'b0);
			check_bit("system_hold", system_hold, 1'b0);
			check_pack_state(psx_loader_top_inst.ram_word_packer_inst.state, PK_IDLE);
		end
		load_ram_words(IDX_BIOS, BIOS_BASE, 12);
		load_ram_words(IDX_EXE, EXE_BASE, 12);
		load_track_info(8);
		load_cheats(4);
		check_disc_state();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
psx_loader_pkg.sv
download_decoder.sv
ram_word_packer.sv
cheat_code_assembler.sv
disc_tracker.sv
psx_loader_top.sv
tb_psx_loader.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PSX loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_psx_loader -o tb_psx_loader -f sim.f; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_psx_loader 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1
